/* ifetch_cfg.svh */
// Address widths, cache geometry and counter width for the fetch subsystem
`ifndef IFETCH_CFG_SVH
`define IFETCH_CFG_SVH

// Base sizes
`define IF_ADDR_W    32                            // Byte address
`define IF_CACHE_AW  11                            // 2 KB cache
`define IF_BLOCK_AW  6                             // 64 byte blocks
`define IF_DATA_W    32                            // Instruction word
`define IF_MISS_W    16                            // Miss counter

// Derived address fields
`define IF_WADDR_W   (`IF_ADDR_W - 2)              // Word address, 30
`define IF_TAG_W     (`IF_ADDR_W - `IF_CACHE_AW)   // 21
`define IF_BLK_W     (`IF_CACHE_AW - `IF_BLOCK_AW) // Block index, 5
`define IF_WORD_W    (`IF_BLOCK_AW - 2)            // Word in block, 4
`define IF_LINE_W    (`IF_CACHE_AW - 2)            // Line address, 9

// Array depths
`define IF_WORDS     (1 << `IF_WORD_W)             // Words per block
`define IF_BLOCKS    (1 << `IF_BLK_W)              // Tag entries
`define IF_LINES     (1 << `IF_LINE_W)             // Data words

`endif

/* ifetch_pkg.sv */
// Fetch and config payload structs, lookup and refill state enums
`include "ifetch_cfg.svh"

package ifetch_pkg;

   typedef struct packed {
      logic [`IF_WADDR_W-1:0] waddr;   // Word address
   } fetch_req_t;

   typedef struct packed {
      logic [`IF_DATA_W-1:0] word;     // Instruction
   } fetch_rsp_t;

   // One tag per block, one valid bit per word
   typedef struct packed {
      logic [`IF_TAG_W-1:0] tag;
      logic [`IF_WORDS-1:0] wvld;
   } tag_entry_t;

   typedef enum logic [1:0] {
      CFG_ENABLE      = 2'd0,
      CFG_DISABLE     = 2'd1,
      CFG_FLUSH       = 2'd2,
      CFG_READ_MISSES = 2'd3
   } cfg_op_e;

   typedef struct packed {
      cfg_op_e op;
   } cfg_cmd_t;

   typedef struct packed {
      logic [`IF_MISS_W-1:0] misses;
   } cfg_rsp_t;

   // Lookup FSM and refill FSM states
   typedef enum logic [1:0] {LK_IDLE, LK_LOOKUP, LK_WAIT_FILL, LK_ACK} lookup_state_e;
   typedef enum logic [1:0] {RF_IDLE, RF_MEM_REQ, RF_MEM_RELEASE, RF_DONE} refill_state_e;

endpackage

/* icache_tag_ram.sv */
// Tag and word-valid array, registered write, combinational read
`timescale 1ns/10ps
`include "ifetch_cfg.svh"

module icache_tag_ram (
   input  logic                   gclk,
   input  logic                   we_i,
   input  logic [`IF_BLK_W-1:0]   idx_i,
   input  ifetch_pkg::tag_entry_t wdata_i,
   output ifetch_pkg::tag_entry_t rdata_o
);
   import ifetch_pkg::*;

   tag_entry_t mem [`IF_BLOCKS];   // One entry per block

   // Write on fill
   always_ff @(posedge gclk) begin
      if (we_i) begin
         mem[idx_i] <= wdata_i;
      end
   end

   // Async read for the hit check
   assign rdata_o = mem[idx_i];

   // A write through an unknown index would corrupt an unknown entry
   a_idx_known : assert property (
      @(posedge gclk) we_i |-> !$isunknown(idx_i)
   ) else $error("tag ram write with unknown index %h", idx_i);

endmodule

/* icache_data_ram.sv */
// Instruction data array, fill write port and registered lookup read port
`timescale 1ns/10ps
`include "ifetch_cfg.svh"

module icache_data_ram (
   input  logic                   gclk,
   input  logic                   fill_we_i,
   input  logic [`IF_LINE_W-1:0]  fill_addr_i,
   input  logic [`IF_DATA_W-1:0]  fill_data_i,
   input  logic                   rd_en_i,
   input  logic [`IF_LINE_W-1:0]  rd_addr_i,
   output logic [`IF_DATA_W-1:0]  rd_data_o
);

   logic [`IF_DATA_W-1:0] mem [`IF_LINES];   // One word per line

   // Fill port
   always_ff @(posedge gclk) begin
      if (fill_we_i) begin
         mem[fill_addr_i] <= fill_data_i;
      end
   end

   // Lookup port, output held between reads
   always_ff @(posedge gclk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

   // Fill and lookup never touch the array in the same cycle
   // since the cache only fills while its lookup waits

endmodule

/* icache.sv */
// Direct-mapped instruction cache with per-word valid bits
// Lookup FSM, hit check, block-valid register and fill merge
`timescale 1ns/10ps
`include "ifetch_cfg.svh"

module icache (
   input  logic                   gclk,
   input  logic                   grst,
   input  logic                   cpu_req_i,
   input  ifetch_pkg::fetch_req_t cpu_addr_i,
   output logic                   cpu_ack_o,
   output ifetch_pkg::fetch_rsp_t cpu_rsp_o,
   input  logic                   cache_en_i,
   input  logic                   flush_i,
   output logic                   miss_o,
   output logic                   miss_req_o,
   output ifetch_pkg::fetch_req_t miss_addr_o,
   input  logic                   fill_done_i,
   input  ifetch_pkg::fetch_rsp_t fill_rsp_i
);
   import ifetch_pkg::*;

   lookup_state_e          state_q;
   fetch_req_t             addr_q;      // Held from lookup to ack
   fetch_rsp_t             rsp_q;
   logic [`IF_TAG_W-1:0]   tag_q;
   logic [`IF_BLK_W-1:0]   blk_q;
   logic [`IF_WORD_W-1:0]  word_q;
   logic [`IF_LINE_W-1:0]  line_q;
   logic [`IF_WORDS-1:0]   word_mask;   // One-hot word decode
   logic [`IF_BLOCKS-1:0]  blk_vld_q;
   tag_entry_t             tag_rd, tag_eff, tag_wr;
   logic [`IF_DATA_W-1:0]  ram_word;
   logic                   tag_hit, hit, fill_we, lookup_start, miss_q;

   // Address fields
   assign tag_q  = addr_q.waddr[`IF_WADDR_W-1:`IF_LINE_W];
   assign blk_q  = addr_q.waddr[`IF_LINE_W-1:`IF_WORD_W];
   assign word_q = addr_q.waddr[`IF_WORD_W-1:0];
   assign line_q = addr_q.waddr[`IF_LINE_W-1:0];

   always_comb begin
      word_mask = '0;
      word_mask[word_q] = 1'b1;
   end

   // Invalid block reads as tag zero, no words
   assign tag_eff = blk_vld_q[blk_q] ? tag_rd : '0;
   assign tag_hit = (tag_eff.tag == tag_q);
   assign hit     = cache_en_i && tag_hit && |(tag_eff.wvld & word_mask);

   // Same tag adds one word, new tag replaces the block
   assign tag_wr.tag  = tag_q;
   assign tag_wr.wvld = tag_hit ? (tag_eff.wvld | word_mask) : word_mask;

   assign lookup_start = (state_q == LK_IDLE) && cpu_req_i;
   assign fill_we      = (state_q == LK_WAIT_FILL) && fill_done_i && cache_en_i;

   always_ff @(posedge gclk or posedge grst) begin
      if (grst) begin
         state_q   <= LK_IDLE;
         blk_vld_q <= '0;
         miss_q    <= 1'b0;
      end else begin
         miss_q <= (state_q == LK_LOOKUP) && !hit && cache_en_i;   // Counted misses only
         if (flush_i) begin
            blk_vld_q <= '0;
         end else if (fill_we) begin
            blk_vld_q[blk_q] <= 1'b1;
         end
         case (state_q)
            LK_IDLE: if (cpu_req_i) state_q <= LK_LOOKUP;
            LK_LOOKUP: state_q <= hit ? LK_ACK : LK_WAIT_FILL;
            LK_WAIT_FILL: if (fill_done_i) state_q <= LK_ACK;
            LK_ACK: if (!cpu_req_i) state_q <= LK_IDLE;   // Hold ack until req drops
            default: state_q <= LK_IDLE;
         endcase
      end
   end

   // Payload registers
   always_ff @(posedge gclk) begin
      if (lookup_start) addr_q <= cpu_addr_i;
      if (state_q == LK_LOOKUP && hit) rsp_q.word <= ram_word;
      else if (state_q == LK_WAIT_FILL && fill_done_i) rsp_q <= fill_rsp_i;
   end

   assign cpu_ack_o   = (state_q == LK_ACK);
   assign cpu_rsp_o   = rsp_q;
   assign miss_o      = miss_q;
   assign miss_req_o  = (state_q == LK_WAIT_FILL);   // Level request to refill
   assign miss_addr_o = addr_q;

   icache_tag_ram u_tag_ram (
      .gclk    (gclk),
      .we_i    (fill_we),
      .idx_i   (blk_q),
      .wdata_i (tag_wr),
      .rdata_o (tag_rd)
   );

   icache_data_ram u_data_ram (
      .gclk        (gclk),
      .fill_we_i   (fill_we),
      .fill_addr_i (line_q),
      .fill_data_i (fill_rsp_i.word),
      .rd_en_i     (lookup_start),
      .rd_addr_i   (cpu_addr_i.waddr[`IF_LINE_W-1:0]),
      .rd_data_o   (ram_word)
   );

   a_ack_after_req : assert property (
      @(posedge gclk) disable iff (grst) $rose(cpu_ack_o) |-> $past(cpu_req_i)
   ) else $error("cpu_ack_o rose without cpu_req_i");

   a_miss_stable : assert property (
      @(posedge gclk) disable iff (grst)
      miss_req_o && !fill_done_i |=> miss_req_o && $stable(miss_addr_o)
   ) else $error("miss_req_o or miss_addr_o changed before fill_done");

endmodule

/* icache_refill.sv */
// Refill FSM, fetches one word over the memory four-phase handshake
`timescale 1ns/10ps
`include "ifetch_cfg.svh"

module icache_refill (
   input  logic                   gclk,
   input  logic                   grst,
   input  logic                   miss_req_i,
   input  ifetch_pkg::fetch_req_t miss_addr_i,
   output logic                   fill_done_o,
   output ifetch_pkg::fetch_rsp_t fill_rsp_o,
   output logic                   mem_req_o,
   output ifetch_pkg::fetch_req_t mem_addr_o,
   input  logic                   mem_ack_i,
   input  ifetch_pkg::fetch_rsp_t mem_rsp_i
);
   import ifetch_pkg::*;

   refill_state_e state_q;
   fetch_req_t    addr_q;   // Captured with the miss
   fetch_rsp_t    rsp_q;    // Captured with mem ack

   always_ff @(posedge gclk or posedge grst) begin
      if (grst) begin
         state_q <= RF_IDLE;
      end else begin
         case (state_q)
            RF_IDLE: begin
               if (miss_req_i) begin
                  state_q <= RF_MEM_REQ;
               end
            end
            RF_MEM_REQ: begin
               // Memory may stall here indefinitely
               if (mem_ack_i) begin
                  state_q <= RF_MEM_RELEASE;
               end
            end
            RF_MEM_RELEASE: begin
               if (!mem_ack_i) begin
                  state_q <= RF_DONE;
               end
            end
            RF_DONE: state_q <= RF_IDLE;   // Cache drops miss_req here
            default: state_q <= RF_IDLE;
         endcase
      end
   end

   always_ff @(posedge gclk) begin
      if (state_q == RF_IDLE && miss_req_i) begin
         addr_q <= miss_addr_i;
      end
      if (state_q == RF_MEM_REQ && mem_ack_i) begin
         rsp_q <= mem_rsp_i;
      end
   end

   assign mem_req_o   = (state_q == RF_MEM_REQ);
   assign mem_addr_o  = addr_q;
   assign fill_done_o = (state_q == RF_DONE);   // Single cycle pulse
   assign fill_rsp_o  = rsp_q;

   // Request withdrawn only once memory has answered
   a_req_held : assert property (
      @(posedge gclk) disable iff (grst) $fell(mem_req_o) |-> $past(mem_ack_i)
   ) else $error("mem_req_o fell before mem_ack_i");

endmodule

/* icache_ctrl_regs.sv */
// Cache enable and flush control, saturating miss counter, config port
`timescale 1ns/10ps
`include "ifetch_cfg.svh"

module icache_ctrl_regs (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 cfg_req_i,
   input  ifetch_pkg::cfg_cmd_t cfg_cmd_i,
   output logic                 cfg_ack_o,
   output ifetch_pkg::cfg_rsp_t cfg_rsp_o,
   input  logic                 miss_i,
   output logic                 cache_en_o,
   output logic                 flush_o
);
   import ifetch_pkg::*;

   logic [`IF_MISS_W-1:0] miss_cnt_q;
   logic                  cmd_start;

   assign cmd_start = cfg_req_i && !cfg_ack_o;   // Rising edge of the request

   always_ff @(posedge gclk or posedge grst) begin
      if (grst) begin
         cfg_ack_o  <= 1'b0;
         cache_en_o <= 1'b1;   // Cache on out of reset
         flush_o    <= 1'b0;
         miss_cnt_q <= '0;
      end else begin
         flush_o <= 1'b0;
         if (cmd_start) begin
            cfg_ack_o <= 1'b1;
            case (cfg_cmd_i.op)
               CFG_ENABLE:  cache_en_o <= 1'b1;
               CFG_DISABLE: cache_en_o <= 1'b0;
               CFG_FLUSH:   flush_o    <= 1'b1;
               default: ;   // Read handled with the payload
            endcase
         end else if (!cfg_req_i) begin
            cfg_ack_o <= 1'b0;
         end
         if (miss_i && !(&miss_cnt_q)) begin
            miss_cnt_q <= miss_cnt_q + 1'b1;   // Sticks at all ones
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (cmd_start && cfg_cmd_i.op == CFG_READ_MISSES) begin
         cfg_rsp_o.misses <= miss_cnt_q;
      end
   end

endmodule

/* ifetch_top.sv */
// Fetch subsystem top, cache with refill unit and control registers
`timescale 1ns/10ps

module ifetch_top (
   input  logic                   gclk,
   input  logic                   grst,
   input  logic                   cpu_req_i,
   input  ifetch_pkg::fetch_req_t cpu_addr_i,
   output logic                   cpu_ack_o,
   output ifetch_pkg::fetch_rsp_t cpu_rsp_o,
   output logic                   mem_req_o,
   output ifetch_pkg::fetch_req_t mem_addr_o,
   input  logic                   mem_ack_i,
   input  ifetch_pkg::fetch_rsp_t mem_rsp_i,
   input  logic                   cfg_req_i,
   input  ifetch_pkg::cfg_cmd_t   cfg_cmd_i,
   output logic                   cfg_ack_o,
   output ifetch_pkg::cfg_rsp_t   cfg_rsp_o
);
   import ifetch_pkg::*;

   fetch_req_t miss_addr;
   fetch_rsp_t fill_rsp;
   logic       miss_req, fill_done, cache_en, flush, miss;

   icache u_icache (
      .gclk, .grst, .cpu_req_i, .cpu_addr_i, .cpu_ack_o, .cpu_rsp_o,
      .cache_en_i (cache_en),
      .flush_i    (flush),
      .miss_o     (miss),
      .miss_req_o (miss_req),
      .miss_addr_o(miss_addr),
      .fill_done_i(fill_done),
      .fill_rsp_i (fill_rsp)
   );

   icache_refill u_refill (
      .gclk, .grst, .mem_req_o, .mem_addr_o, .mem_ack_i, .mem_rsp_i,
      .miss_req_i (miss_req),
      .miss_addr_i(miss_addr),
      .fill_done_o(fill_done),
      .fill_rsp_o (fill_rsp)
   );

   icache_ctrl_regs u_ctrl (
      .gclk, .grst, .cfg_req_i, .cfg_cmd_i, .cfg_ack_o, .cfg_rsp_o,
      .miss_i     (miss),
      .cache_en_o (cache_en),
      .flush_o    (flush)
   );

endmodule

/* tb_ifetch.sv */
// Testbench for the fetch subsystem
// Clock, reset, memory model, stimulus table with checks, watchdog
`timescale 1ns/10ps
`include "ifetch_cfg.svh"

module tb_ifetch;
   import ifetch_pkg::*;

   typedef struct packed {
      logic                   is_cfg;    // Config command, else fetch
      cfg_op_e                op;
      logic [`IF_WADDR_W-1:0] waddr;
      logic [`IF_DATA_W-1:0]  exp_val;   // Word or miss count
      logic [3:0]             exp_hs;    // New memory handshakes
   } entry_t;

   localparam int MAX_ENTRIES = 64;
   localparam logic [`IF_DATA_W-1:0] MEM_XOR = 32'hA5A5_0000;
   // Word addresses, tag in [29:9], block in [8:4], word in [3:0]
   localparam logic [`IF_WADDR_W-1:0] ADDR_A = 30'h232;   // Tag 1, block 3, word 2
   localparam logic [`IF_WADDR_W-1:0] ADDR_B = 30'h235;   // Tag 1, block 3, word 5
   localparam logic [`IF_WADDR_W-1:0] ADDR_C = 30'h432;   // Tag 2, block 3, word 2
   localparam logic [`IF_WADDR_W-1:0] ADDR_E = 30'hA70;   // Tag 5, block 7
   localparam logic [`IF_WADDR_W-1:0] ADDR_F = 30'hE91;   // Tag 7, block 9

   logic       gclk = 1'b0;
   logic       grst, cpu_req, cpu_ack, mem_req, mem_ack, cfg_req, cfg_ack;
   fetch_req_t cpu_addr, mem_addr;
   fetch_rsp_t cpu_rsp, mem_rsp;
   cfg_cmd_t   cfg_cmd;
   cfg_rsp_t   cfg_rsp;

   entry_t tbl [MAX_ENTRIES];
   int     n_entries = 0;
   logic   tbl_ready = 1'b0;
   logic   tbl_en    = 1'b1;        // Enable state while building
   int     miss_tally = 0;
   int     mem_hs     = 0;          // Memory handshakes so far
   int     mem_delay;
   integer seed = 32'h5d01_c02c;

   always #5 gclk = ~gclk;          // 10 ns period

   ifetch_top DUT (
      .gclk, .grst,
      .cpu_req_i (cpu_req), .cpu_addr_i (cpu_addr), .cpu_ack_o (cpu_ack), .cpu_rsp_o (cpu_rsp),
      .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_ack_i (mem_ack), .mem_rsp_i (mem_rsp),
      .cfg_req_i (cfg_req), .cfg_cmd_i  (cfg_cmd),  .cfg_ack_o (cfg_ack), .cfg_rsp_o (cfg_rsp)
   );

   // Memory contents rule
   function automatic logic [`IF_DATA_W-1:0] mem_word(input logic [`IF_WADDR_W-1:0] waddr);
      return {2'b00, waddr} ^ MEM_XOR;
   endfunction

   // Memory model, random 0 to 3 cycle answer
   always @(negedge gclk) begin
      if (mem_req && !mem_ack) begin
         mem_delay = $random(seed) & 32'd3;
         repeat (mem_delay) @(negedge gclk);
         mem_rsp.word = mem_word(mem_addr.waddr);
         mem_ack = 1'b1;
         mem_hs++;
      end else if (!mem_req && mem_ack) begin
         mem_ack = 1'b0;                         // Release phase
      end
   end

   task automatic check_hex(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         $display("sim failed");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic add_fetch(input logic [`IF_WADDR_W-1:0] waddr, input int hs);
      entry_t e;
      e = '0;
      e.waddr   = waddr;
      e.exp_val = mem_word(waddr);
      e.exp_hs  = hs[3:0];
      if (tbl_en && hs != 0) miss_tally++;   // Counted only while enabled
      tbl[n_entries] = e;
      n_entries++;
   endtask

   task automatic add_cfg(input cfg_op_e op);
      entry_t e;
      e = '0;
      e.is_cfg  = 1'b1;
      e.op      = op;
      e.exp_val = 32'(miss_tally);
      if (op == CFG_ENABLE) tbl_en = 1'b1;
      else if (op == CFG_DISABLE) tbl_en = 1'b0;
      tbl[n_entries] = e;
      n_entries++;
   endtask

   task automatic build_table();
      add_fetch(ADDR_A, 1);  add_fetch(ADDR_A, 0);   // Fill then hit
      add_fetch(ADDR_B, 1);  add_fetch(ADDR_B, 0);   // Second word, same tag
      add_fetch(ADDR_A, 0);
      add_fetch(ADDR_C, 1);  add_fetch(ADDR_C, 0);   // New tag replaces block
      add_fetch(ADDR_B, 1);  add_fetch(ADDR_A, 1);   // Old neighbours miss again
      add_fetch(ADDR_B, 0);
      add_fetch(ADDR_E, 1);  add_fetch(ADDR_E, 0);
      add_cfg(CFG_READ_MISSES);
      add_cfg(CFG_FLUSH);
      add_fetch(ADDR_A, 1);  add_fetch(ADDR_B, 1);  add_fetch(ADDR_E, 1);
      add_fetch(ADDR_A, 0);  add_fetch(ADDR_B, 0);  add_fetch(ADDR_E, 0);
      add_cfg(CFG_DISABLE);
      add_fetch(ADDR_F, 1);  add_fetch(ADDR_F, 1);  add_fetch(ADDR_A, 1);
      add_cfg(CFG_READ_MISSES);                      // Disabled misses not counted
      add_cfg(CFG_ENABLE);
      add_fetch(ADDR_F, 1);  add_fetch(ADDR_F, 0);  add_fetch(ADDR_E, 0);
      add_cfg(CFG_READ_MISSES);
   endtask

   // Full four-phase fetch, starts and ends on a falling edge
   task automatic do_fetch(input entry_t e);
      int hs_before;
      int cycles;
      hs_before = mem_hs;
      cpu_addr.waddr = e.waddr;
      cpu_req = 1'b1;
      @(negedge gclk);
      cycles = 1;
      while (!cpu_ack) begin
         @(negedge gclk);
         cycles++;
      end
      check_hex("cpu_rsp_o", cpu_rsp.word, e.exp_val);
      check_hex("mem handshakes", 32'(mem_hs - hs_before), {28'h0, e.exp_hs});
      if (e.exp_hs == 0) check_hex("cpu_ack_o hit latency", 32'(cycles), 32'd2);
      cpu_req = 1'b0;
      while (cpu_ack) @(negedge gclk);
   endtask

   task automatic do_cfg(input entry_t e);
      int cycles;
      cfg_cmd.op = e.op;
      cfg_req = 1'b1;
      @(negedge gclk);
      cycles = 1;
      while (!cfg_ack) begin
         @(negedge gclk);
         cycles++;
      end
      check_hex("cfg_ack_o latency", 32'(cycles), 32'd1);
      if (e.op == CFG_READ_MISSES) check_hex("cfg_rsp_o", {16'h0, cfg_rsp.misses}, e.exp_val);
      cfg_req = 1'b0;
      while (cfg_ack) @(negedge gclk);
   endtask

   initial begin
      grst     = 1'b1;
      cpu_req  = 1'b0;
      cpu_addr = '0;
      mem_ack  = 1'b0;
      mem_rsp  = '0;
      cfg_req  = 1'b0;
      cfg_cmd  = '0;
      build_table();
      tbl_ready = 1'b1;
      repeat (2) @(posedge gclk);
      @(negedge gclk);
      grst = 1'b0;
      for (int i = 0; i < n_entries; i++) begin
         if (tbl[i].is_cfg) do_cfg(tbl[i]);
         else do_fetch(tbl[i]);
      end
      $display("sim passed");
      $finish;
   end

   // Watchdog, 50 cycles per table entry
   initial begin
      wait (tbl_ready);
      repeat (n_entries * 50) @(posedge gclk);
      $display("sim failed");
      $fatal(1, "timeout, the table did not complete within %0d cycles", n_entries * 50);
   end

endmodule

/* ifetch_top.f */
+incdir+.
ifetch_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache.sv
icache_refill.sv
icache_ctrl_regs.sv
ifetch_top.sv
tb_ifetch.sv

/* Makefile */
# Verilator build of the fetch subsystem testbench
TOP := tb_ifetch
SRC := $(filter-out +incdir+%,$(shell cat ifetch_top.f)) ifetch_cfg.svh

.PHONY: all run clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): $(SRC) ifetch_top.f
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
		--top-module $(TOP) -f ifetch_top.f -o V$(TOP)

# Exit status of the simulator is the pass or fail result
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
